/* vlog.f */
design/board_bus_pkg.sv
design/cabinet_pkg.sv
design/cpu_bus_if.sv
design/bus_decoder.sv
design/work_ram.sv
design/security_shifter.sv
design/cabinet_inputs.sv
design/rom_fetch.sv
design/main_board.sv
dv/main_board_checker.sv
dv/main_board_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module main_board_tb -o main_board_sim
out=$(./obj_dir/main_board_sim +verilator+error+limit+100)
echo "$out"

if grep -qx "sim passed" <<< "$out"; then
    exit 0
fi
exit 1

/* dv/main_board_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module main_board_tb;
    import board_bus_pkg::*;

    localparam int ROM_DEPTH = 2;   // Memory request queue
    localparam int RSP_LAT   = 3;   // Request to response, cycles
    localparam int HOLD_LEN  = 30;  // Credit hold-back window

    typedef enum logic [2:0] {K_RD, K_WR, K_IORD, K_IOWR, K_HOLD} kind_e;
    typedef enum logic [1:0] {C_LOCAL, C_ROM, C_STALL, C_VRAM} class_e;

    typedef struct packed {
        kind_e  kind;
        addr_t  caddr;      // Clean address
        addr_t  addr;       // As seen on the CPU pins
        data_t  wdata;
        data_t  exp;
        class_e cls;
    } entry_t;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    addr_t       bus_addr = '0;
    data_t       bus_wdata = '0;
    logic        bus_rd = 1'b0;
    logic        bus_wr = 1'b0;
    logic        bus_iorq = 1'b0;
    data_t       bus_rdata;
    logic        bus_ready;
    logic        rom_req_valid;
    logic [14:0] rom_req_addr;
    logic        rom_credit = 1'b0;
    logic        rom_rsp_valid = 1'b0;
    data_t       rom_rsp_data = '0;
    logic        vram_we;
    logic        vram_sel;
    addr_t       vram_addr;
    data_t       vram_data;
    logic [4:0]  joy1 = 5'b10110;       // Punch, down, left
    logic [4:0]  joy2 = 5'b01001;       // Up, right
    logic [1:0]  start = 2'b10;
    logic        coin = 1'b0;
    logic        service = 1'b1;
    logic [3:0]  dip1 = 4'b1100;
    logic [7:0]  dip2 = 8'ha5;
    logic        flip;

    entry_t tbl[$];
    int     errors = 0;
    int     model_errs = 0;
    int     checks = 0;
    int     cycles = 0;
    int     limit = 0;
    int     seed = 32'hcc75_45ea;

    main_board #(.ROM_CREDITS(ROM_DEPTH), .RAM_AW(11)) dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timed out after %0d cycles waiting for bus ready", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // CPU pins from a clean address, inverse of the board wiring
    function automatic addr_t scramble(input addr_t c);
        addr_t s;
        s[2:0]   = ~c[2:0];
        s[4]     = ~c[3];
        s[5]     = ~c[4];
        s[9]     = ~c[5];
        s[3]     = c[6];
        s[6]     = c[7];
        s[7]     = c[8];
        s[8]     = c[9];
        s[15:10] = c[15:10];
        return s;
    endfunction

    function automatic data_t rom_data_for(input addr_t a);
        return a[7:0] ^ 8'h5a;
    endfunction

    //////////////////////////////////////////////////
    // ROM model, queue of two with slow slot release
    int          slots = 0;         // Requests holding a queue slot
    int          rsp_cnt = 0;
    int          free_cnt = 0;      // Cycles to the next slot release
    int          hold_cycles = 0;
    int          hold_id = 0;       // Bumped by the bus side
    int          hold_seen = 0;
    logic [14:0] rsp_addr = '0;

    always @(posedge clk) begin
        rom_credit    <= 1'b0;
        rom_rsp_valid <= 1'b0;
        if (!rst_n) begin
            slots    = 0;
            rsp_cnt  = 0;
            free_cnt = 0;
        end else begin
            if (rom_req_valid) begin
                if (slots == ROM_DEPTH) begin
                    model_errs++;
                    $display("ROM request arrived at %0t with the queue full", $time);
                end
                slots++;
                rsp_addr = rom_req_addr;
                rsp_cnt  = RSP_LAT;
            end else if (rsp_cnt > 0) begin
                rsp_cnt--;
                if (rsp_cnt == 0) begin
                    rom_rsp_valid <= 1'b1;
                    rom_rsp_data  <= rom_data_for({1'b0, rsp_addr});
                end
            end
            if (hold_id != hold_seen) begin
                hold_seen   = hold_id;
                hold_cycles = HOLD_LEN;
            end
            if (hold_cycles > 0) begin
                hold_cycles--;          // Credits kept back
            end else if (slots > 0) begin
                if (free_cnt == 0) begin
                    free_cnt = 1 + int'($unsigned($random(seed)) % 4);
                end
                free_cnt--;
                if (free_cnt == 0) begin
                    rom_credit <= 1'b1;
                    slots--;
                end
            end
        end
    end

    // Video write monitor
    int    vram_cnt = 0;
    addr_t vram_seen_addr;
    data_t vram_seen_data;
    logic  vram_seen_sel;

    always @(negedge clk) begin
        if (vram_we) begin
            vram_cnt++;
            vram_seen_addr = vram_addr;
            vram_seen_data = vram_data;
            vram_seen_sel  = vram_sel;
        end
    end

    //////////////////////////////////////////////////
    // Compare tasks
    task automatic check_data(input data_t got, input data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_vram(input addr_t exp_addr, input data_t exp_data, input bit exp_sel);
        checks++;
        if (vram_seen_addr !== exp_addr || vram_seen_data !== exp_data
            || vram_seen_sel !== exp_sel) begin
            errors++;
            $display("FAILED %0t: vram write %h/%h/%b, expected %h/%h/%b", $time,
                     vram_seen_addr, vram_seen_data, vram_seen_sel,
                     exp_addr, exp_data, exp_sel);
        end
    endtask

    task automatic add_entry(input kind_e k, input addr_t a, input data_t wd,
                             input data_t ex, input class_e c);
        tbl.push_back('{k, a, scramble(a), wd, ex, c});
    endtask

    // One CPU access, held until ready
    task automatic run_entry(input entry_t e);
        int lat;
        int vram_base;
        bit held;
        if (e.kind == K_HOLD) begin
            do @(negedge clk); while (slots != 0);  // Queue drained first
            hold_id = hold_id + 1;
            return;
        end
        @(posedge clk);
        bus_addr  <= e.addr;
        bus_wdata <= e.wdata;
        bus_iorq  <= (e.kind == K_IORD) || (e.kind == K_IOWR);
        bus_rd    <= (e.kind == K_RD) || (e.kind == K_IORD);
        bus_wr    <= (e.kind == K_WR) || (e.kind == K_IOWR);
        vram_base = vram_cnt;
        lat       = 0;
        held      = 1'b0;
        do begin
            @(negedge clk);
            if (lat == 0) held = (hold_cycles > 0);
            lat++;
        end while (!bus_ready);
        // Strobe seen in the first cycle, ready two cycles later
        if ((e.cls == C_LOCAL || e.cls == C_VRAM) && lat != 3) begin
            errors++;
            $display("Ready for access at %h came %0d cycles after the strobe, expected 2",
                     e.caddr, lat - 1);
        end
        if (e.kind == K_RD || e.kind == K_IORD) begin
            check_data(bus_rdata, e.exp, $sformatf("read at %h", e.caddr));
        end
        if (e.cls == C_VRAM) begin
            if (vram_cnt - vram_base != 1) begin
                errors++;
                $display("Expected one vram write for %h, saw %0d", e.caddr,
                         vram_cnt - vram_base);
            end else begin
                check_vram(e.caddr, e.wdata, e.caddr[15:13] == 3'b110);
            end
        end else if (vram_cnt != vram_base) begin
            errors++;
            $display("Unexpected vram write during access at %h", e.caddr);
        end
        if (e.cls == C_STALL && (!held || hold_cycles > 0)) begin
            errors++;
            $display("ROM read at %h was not held back until credits returned", e.caddr);
        end
        @(posedge clk);
        bus_rd   <= 1'b0;
        bus_wr   <= 1'b0;
        bus_iorq <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    initial begin
        // ROM reads, then a ROM write that is dropped
        add_entry(K_RD, 16'h0012, 8'h00, rom_data_for(16'h0012), C_ROM);
        add_entry(K_RD, 16'h1234, 8'h00, rom_data_for(16'h1234), C_ROM);
        add_entry(K_RD, 16'h7ffe, 8'h00, rom_data_for(16'h7ffe), C_ROM);
        add_entry(K_RD, 16'h5a5a, 8'h00, rom_data_for(16'h5a5a), C_ROM);
        add_entry(K_WR, 16'h0100, 8'h77, 8'h00, C_LOCAL);
        // Credits held, third read must wait
        add_entry(K_HOLD, 16'h0000, 8'h00, 8'h00, C_LOCAL);
        add_entry(K_RD, 16'h2001, 8'h00, rom_data_for(16'h2001), C_ROM);
        add_entry(K_RD, 16'h3002, 8'h00, rom_data_for(16'h3002), C_ROM);
        add_entry(K_RD, 16'h4003, 8'h00, rom_data_for(16'h4003), C_STALL);
        // Work RAM, bit 11 set is open bus
        add_entry(K_WR, 16'h8123, 8'h3c, 8'h00, C_LOCAL);
        add_entry(K_WR, 16'h87fe, 8'hc3, 8'h00, C_LOCAL);
        add_entry(K_RD, 16'h8123, 8'h00, 8'h3c, C_LOCAL);
        add_entry(K_RD, 16'h87fe, 8'h00, 8'hc3, C_LOCAL);
        add_entry(K_WR, 16'h8923, 8'hee, 8'h00, C_LOCAL);
        add_entry(K_RD, 16'h8923, 8'h00, 8'hff, C_LOCAL);
        add_entry(K_RD, 16'h8123, 8'h00, 8'h3c, C_LOCAL);   // No alias write
        // Video windows
        add_entry(K_WR, 16'ha123, 8'h55, 8'h00, C_VRAM);
        add_entry(K_WR, 16'hc456, 8'haa, 8'h00, C_VRAM);
        add_entry(K_RD, 16'ha123, 8'h00, 8'hff, C_LOCAL);
        add_entry(K_RD, 16'hc456, 8'h00, 8'hff, C_LOCAL);
        // Security, shift 3 of 16'h963c
        add_entry(K_WR, 16'he001, 8'h03, 8'h00, C_LOCAL);
        add_entry(K_WR, 16'he000, 8'h96, 8'h00, C_LOCAL);
        add_entry(K_WR, 16'he000, 8'h3c, 8'h00, C_LOCAL);
        add_entry(K_RD, 16'he000, 8'h00, 8'hb1, C_LOCAL);
        // Cabinet ports, dip_sel 3 and flip set
        add_entry(K_IORD, 16'h0000, 8'h00, 8'h8c, C_LOCAL);
        add_entry(K_IOWR, 16'h0000, 8'h07, 8'h00, C_LOCAL);
        add_entry(K_IOWR, 16'h0001, 8'hff, 8'h00, C_LOCAL); // Ignored
        add_entry(K_IORD, 16'h0000, 8'h00, 8'h0c, C_LOCAL);
        add_entry(K_IORD, 16'h0001, 8'h00, 8'h7b, C_LOCAL);
        add_entry(K_IORD, 16'h0002, 8'h00, 8'he5, C_LOCAL);
        add_entry(K_IORD, 16'h0003, 8'h00, 8'hfa, C_LOCAL);
        limit = tbl.size() * 20 + 100;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_data({4'b0, bus_ready, rom_req_valid, vram_we, flip}, 8'h00, "outputs after reset");
        foreach (tbl[i]) begin
            run_entry(tbl[i]);
        end
        check_data({7'b0, flip}, 8'h01, "flip latch");
        repeat (4) @(posedge clk);

        errors = errors + model_errs + dut_i.checker_i.fail_cnt;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/main_board_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module main_board_checker #(
    parameter int CREDITS = 2
) (
    input wire                    clk,
    input wire                    rst_n,
    input wire                    bus_rd,
    input wire                    bus_wr,
    input wire                    bus_ready,
    input wire                    start,        // First cycle of an access
    input board_bus_pkg::region_e region,
    input wire                    rom_req_valid,
    input wire                    rom_credit
);
    import board_bus_pkg::*;

    int   fail_cnt = 0;         // Failed assertions so far
    int   credits = CREDITS;    // Free slots in the memory queue
    logic local_start;          // Access with fixed timing

    assign local_start = start & ~(bus_rd & (region == REG_ROM));

    always @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDITS;
        end else begin
            credits <= credits - int'(rom_req_valid) + int'(rom_credit);
        end
    end

    //////////////////////////////////////////////////
    // ROM credit channel
    req_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        rom_req_valid |-> credits > 0)
        else begin
            fail_cnt++;
            $error("ROM request issued with zero credits");
        end

    req_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rom_req_valid |=> !rom_req_valid)
        else begin
            fail_cnt++;
            $error("ROM request held longer than one cycle");
        end

    //////////////////////////////////////////////////
    // Bus ready
    local_ready_late: assert property (@(posedge clk) disable iff (!rst_n)
        $past(local_start) |-> !bus_ready)
        else begin
            fail_cnt++;
            $error("Local access gave ready after one cycle");
        end

    local_ready_two: assert property (@(posedge clk) disable iff (!rst_n)
        $past(local_start, 2) |-> bus_ready)
        else begin
            fail_cnt++;
            $error("Local access gave no ready two cycles after the strobe");
        end

    ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        bus_ready |=> !bus_ready)
        else begin
            fail_cnt++;
            $error("Bus ready longer than one cycle");
        end

    ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        bus_ready |-> bus_rd || bus_wr)
        else begin
            fail_cnt++;
            $error("Bus ready outside an access");
        end

endmodule

bind main_board main_board_checker #(.CREDITS(ROM_CREDITS)) checker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus_rd        (bus_rd),
    .bus_wr        (bus_wr),
    .bus_ready     (bus_ready),
    .start         (cpu_bus.start),
    .region        (cpu_bus.region),
    .rom_req_valid (rom_req_valid),
    .rom_credit    (rom_credit)
);

`default_nettype wire

/* design/main_board.sv */
`timescale 1ns/1ps
`default_nettype none

module main_board #(
    parameter int ROM_CREDITS = 2,
    parameter int RAM_AW      = 11
) (
    input  wire                  clk,
    input  wire                  rst_n,
    // CPU bus, scrambled address
    input  board_bus_pkg::addr_t bus_addr,
    input  board_bus_pkg::data_t bus_wdata,
    input  wire                  bus_rd,
    input  wire                  bus_wr,
    input  wire                  bus_iorq,
    output board_bus_pkg::data_t bus_rdata,
    output logic                 bus_ready,
    // Program ROM channel
    output logic                 rom_req_valid,
    output logic [14:0]          rom_req_addr,
    input  wire                  rom_credit,
    input  wire                  rom_rsp_valid,
    input  board_bus_pkg::data_t rom_rsp_data,
    // Video RAM writes
    output logic                 vram_we,
    output logic                 vram_sel,  // 0 text, 1 background
    output board_bus_pkg::addr_t vram_addr,
    output board_bus_pkg::data_t vram_data,
    // Cabinet
    input  wire [4:0]            joy1,
    input  wire [4:0]            joy2,
    input  wire [1:0]            start,
    input  wire                  coin,
    input  wire                  service,
    input  wire [3:0]            dip1,
    input  wire [7:0]            dip2,
    output logic                 flip
);
    import board_bus_pkg::*;

    data_t ram_rdata;
    data_t sec_rdata;
    data_t io_rdata;
    data_t rom_data;
    logic  rom_done;

    cpu_bus_if cpu_bus ();

    // CPU side of the bus
    assign cpu_bus.wdata = bus_wdata;
    assign cpu_bus.rd    = bus_rd;
    assign cpu_bus.wr    = bus_wr;
    assign cpu_bus.iorq  = bus_iorq;
    assign bus_rdata     = cpu_bus.rdata;
    assign bus_ready     = cpu_bus.ready;

    //////////////////////////////////////////////////
    // Decode and slaves
    bus_decoder decoder_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (cpu_bus.decoder),
        .bus_addr_raw (bus_addr),
        .ram_rdata    (ram_rdata),
        .sec_rdata    (sec_rdata),
        .io_rdata     (io_rdata),
        .rom_done     (rom_done),
        .rom_data     (rom_data)
    );

    work_ram #(.RAM_AW(RAM_AW)) ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (cpu_bus.target),
        .rdata (ram_rdata)
    );

    security_shifter security_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (cpu_bus.target),
        .rdata (sec_rdata)
    );

    cabinet_inputs cabinet_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (cpu_bus.target),
        .joy1    (joy1),
        .joy2    (joy2),
        .start   (start),
        .coin    (coin),
        .service (service),
        .dip1    (dip1),
        .dip2    (dip2),
        .rdata   (io_rdata),
        .flip    (flip)
    );

    rom_fetch #(.ROM_CREDITS(ROM_CREDITS)) rom_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (cpu_bus.target),
        .rom_req_valid (rom_req_valid),
        .rom_req_addr  (rom_req_addr),
        .rom_credit    (rom_credit),
        .rom_rsp_valid (rom_rsp_valid),
        .rom_rsp_data  (rom_rsp_data),
        .done          (rom_done),
        .data          (rom_data)
    );

    // Video writes leave on the first cycle only
    assign vram_sel  = (cpu_bus.region == REG_BG);
    assign vram_we   = cpu_bus.start & cpu_bus.wr
                     & (cpu_bus.region == REG_TXT | cpu_bus.region == REG_BG);
    assign vram_addr = cpu_bus.addr;
    assign vram_data = cpu_bus.wdata;

endmodule

`default_nettype wire

/* design/rom_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_fetch #(
    parameter int ROM_CREDITS = 2
) (
    input  wire                  clk,
    input  wire                  rst_n,
    cpu_bus_if.target            bus,
    output logic                 rom_req_valid,
    output logic [14:0]          rom_req_addr,
    input  wire                  rom_credit,    // Memory popped one request
    input  wire                  rom_rsp_valid,
    input  board_bus_pkg::data_t rom_rsp_data,
    output logic                 done,
    output board_bus_pkg::data_t data
);
    import board_bus_pkg::*;

    localparam int CW = $clog2(ROM_CREDITS + 1);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_CREDIT,    // Memory queue full
        WAIT_RSP,
        DONE
    } state_e;

    state_e        state;
    logic [CW-1:0] credits;
    logic          rom_rd;
    logic          has_credit;
    logic          issue;

    assign rom_rd     = bus.start & bus.rd & (bus.region == REG_ROM);
    assign has_credit = (credits != '0);
    assign issue      = has_credit & ((state == IDLE & rom_rd) | (state == WAIT_CREDIT));

    assign rom_req_valid = issue;
    assign rom_req_addr  = bus.addr[14:0];  // CPU holds the address
    assign done          = (state == DONE);

    //////////////////////////////////////////////////
    // Credits follow the memory queue at all times
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CW'(ROM_CREDITS);
        end else begin
            credits <= credits - CW'(issue) + CW'(rom_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:        if (rom_rd) state <= has_credit ? WAIT_RSP : WAIT_CREDIT;
                WAIT_CREDIT: if (has_credit) state <= WAIT_RSP;
                WAIT_RSP:    if (rom_rsp_valid) state <= DONE;
                default:     state <= IDLE;    // Ready shown for one cycle
            endcase
        end
    end

    // Response byte, held until the next one
    always_ff @(posedge clk) begin
        if (state == WAIT_RSP && rom_rsp_valid) begin
            data <= rom_rsp_data;
        end
    end

endmodule

`default_nettype wire

/* design/cabinet_inputs.sv */
`timescale 1ns/1ps
`default_nettype none

module cabinet_inputs (
    input  wire                  clk,
    input  wire                  rst_n,
    cpu_bus_if.target            bus,
    input  wire [4:0]            joy1,      // Punch, up, down, left, right
    input  wire [4:0]            joy2,
    input  wire [1:0]            start,
    input  wire                  coin,
    input  wire                  service,
    input  wire [3:0]            dip1,
    input  wire [7:0]            dip2,
    output board_bus_pkg::data_t rdata,
    output logic                 flip
);
    import board_bus_pkg::*;
    import cabinet_pkg::*;

    cfg_t     cfg_q;
    io_port_e port;

    assign port = io_port_e'(bus.addr[1:0]);

    // Config latch on port 0, other writes dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (bus.start && bus.wr && bus.region == REG_IO && port == IO_CFG_DIP) begin
            cfg_q <= cfg_t'(bus.wdata);
        end
    end

    assign flip = cfg_q.flip;

    //////////////////////////////////////////////////
    // Read ports, open bits float high
    always_comb begin
        rdata = 8'hff;
        case (port)
            IO_CFG_DIP: rdata = {dip2[cfg_q.dip_sel], 3'b000, dip1};
            IO_SYSTEM: begin
                rdata[7]   = coin;
                rdata[6]   = service;
                rdata[3:2] = start;
            end
            IO_P2: rdata = {3'b111, joy2[4], joy2[2], joy2[3], joy2[1:0]};  // Up/down swapped
            IO_P1: rdata = {3'b111, joy1[4], joy1[2], joy1[3], joy1[1:0]};
            default: rdata = 8'hff;
        endcase
    end

endmodule

`default_nettype wire

/* design/security_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module security_shifter (
    input  wire                  clk,
    input  wire                  rst_n,
    cpu_bus_if.target            bus,
    output board_bus_pkg::data_t rdata
);
    import board_bus_pkg::*;

    logic [15:0] sreg;      // Two last bytes pushed
    logic [2:0]  amount;    // Shift offset
    logic [15:0] shifted;
    logic        we;

    assign we = bus.start & bus.wr & (bus.region == REG_SEC);

    //////////////////////////////////////////////////
    // Writes, A0 picks offset or data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sreg   <= '0;
            amount <= '0;
        end else if (we) begin
            if (bus.addr[0]) begin
                amount <= bus.wdata[2:0];
            end else begin
                sreg <= {sreg[7:0], bus.wdata}; // Older byte moves up
            end
        end
    end

    // Read window, registered in the decoder
    assign shifted = sreg << amount;
    assign rdata   = shifted[15:8];

endmodule

`default_nettype wire

/* design/work_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module work_ram #(
    parameter int RAM_AW = 11
) (
    input  wire                  clk,
    input  wire                  rst_n,
    cpu_bus_if.target            bus,
    output board_bus_pkg::data_t rdata
);
    import board_bus_pkg::*;

    data_t             mem [2**RAM_AW];
    logic [RAM_AW-1:0] waddr;
    logic              we;

    assign waddr = bus.addr[RAM_AW-1:0];
    assign we    = bus.start & bus.wr & (bus.region == REG_RAM);  // Once per access

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= bus.wdata;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= '0;
        end else begin
            rdata <= mem[waddr];
        end
    end

endmodule

`default_nettype wire

/* design/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  wire                  clk,
    input  wire                  rst_n,
    cpu_bus_if.decoder           bus,
    input  board_bus_pkg::addr_t bus_addr_raw,  // Straight from the CPU pins
    input  board_bus_pkg::data_t ram_rdata,
    input  board_bus_pkg::data_t sec_rdata,
    input  board_bus_pkg::data_t io_rdata,
    input  wire                  rom_done,
    input  board_bus_pkg::data_t rom_data
);
    import board_bus_pkg::*;

    addr_t   clean;
    region_e region;
    logic    stb;
    logic    seen_q;    // Strobe was high last cycle
    logic    mid_q;     // Second cycle of a local access
    logic    ready_q;
    logic    rom_rd;
    data_t   rdata_q;

    //////////////////////////////////////////////////
    // Descramble, then decode
    always_comb begin
        for (int i = 0; i < ADDR_W; i++) begin
            clean[i] = bus_addr_raw[DESCR_SRC[i]] ^ DESCR_INV[i];
        end
    end

    always_comb begin
        region = REG_ROM;
        if (bus.iorq) begin
            region = REG_IO;
        end else begin
            case (clean[15:13])
                3'b100:  region = clean[11] ? REG_NONE : REG_RAM;  // Only 2 KB fitted
                3'b101:  region = REG_TXT;
                3'b110:  region = REG_BG;
                3'b111:  region = REG_SEC;
                default: region = REG_ROM;
            endcase
        end
    end

    assign bus.addr   = clean;
    assign bus.region = region;

    //////////////////////////////////////////////////
    // Access timing
    assign stb       = bus.rd | bus.wr;
    assign bus.start = stb & ~seen_q;   // Master idles a cycle between accesses
    assign rom_rd    = bus.rd & (region == REG_ROM);  // Variable latency path

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen_q  <= 1'b0;
            mid_q   <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            seen_q  <= stb;
            mid_q   <= bus.start & ~rom_rd;
            ready_q <= mid_q;   // Two cycles after the strobe
        end
    end

    assign bus.ready = ready_q | rom_done;

    // Registered read steering
    always_ff @(posedge clk) begin
        case (region)
            REG_RAM: rdata_q <= ram_rdata;
            REG_SEC: rdata_q <= sec_rdata;
            REG_IO:  rdata_q <= io_rdata;
            default: rdata_q <= 8'hff;  // Video, open bus
        endcase
    end

    assign bus.rdata = (region == REG_ROM) ? rom_data : rdata_q; // ROM data held in rom_fetch

endmodule

`default_nettype wire

/* design/cpu_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;
    import board_bus_pkg::*;

    addr_t   addr;      // Clean address
    data_t   wdata;
    logic    rd;
    logic    wr;
    logic    iorq;
    logic    start;     // First cycle of an access
    region_e region;
    data_t   rdata;
    logic    ready;     // One-cycle completion pulse

    // Address descrambling, decode and read steering
    modport decoder (input rd, wr, iorq, output addr, start, region, rdata, ready);

    // Slaves on the bus
    modport target (input addr, wdata, rd, wr, start, region);

    // CPU side
    modport master (output wdata, rd, wr, iorq, input addr, start, region, rdata, ready);

endinterface

`default_nettype wire

/* design/cabinet_pkg.sv */
`default_nettype none

package cabinet_pkg;

    // I/O ports, picked by clean address bits 1..0
    typedef enum logic [1:0] {
        IO_CFG_DIP = 2'd0,  // DIP read, config latch write
        IO_SYSTEM  = 2'd1,  // Coin, service, start
        IO_P2      = 2'd2,
        IO_P1      = 2'd3
    } io_port_e;

    // Config latch, same bit order as the data byte
    typedef struct packed {
        logic [3:0] unused;
        logic [2:0] dip_sel;    // DIP2 switch shown on port 0 bit 7
        logic       flip;       // Screen flip, bit 0
    } cfg_t;

endpackage

`default_nettype wire

/* design/board_bus_pkg.sv */
`default_nettype none

package board_bus_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Target of one access, after descrambling
    typedef enum logic [2:0] {
        REG_ROM,
        REG_RAM,    // 2 KB work RAM, upper half of the window is open bus
        REG_TXT,
        REG_BG,
        REG_SEC,    // Security shifter
        REG_IO,
        REG_NONE
    } region_e;

    //////////////////////////////////////////////////
    // Board address scrambling
    typedef logic [$clog2(ADDR_W)-1:0] bit_idx_t;   // Scrambled bit index
    typedef bit_idx_t bit_map_t [ADDR_W];           // One entry per clean bit

    // Clean bit i is taken from scrambled bit DESCR_SRC[i]
    localparam bit_map_t DESCR_SRC = '{
        4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd9, 4'd3, 4'd6,
        4'd7, 4'd8, 4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15
    };
    localparam addr_t DESCR_INV = 16'h003f;         // Clean bits 5..0 inverted

endpackage

`default_nettype wire
